// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := p4_port_stats_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
rtl/p4_stats_pkg.sv
rtl/frame_length_tracker.sv
rtl/phys_port_stats.sv
rtl/stats_aggregator.sv
rtl/p4_port_stats_top.sv
verification/p4_port_stats_assert.sv
verification/p4_port_stats_tb.sv

// ==== rtl/frame_length_tracker.sv ====
// Frame length tracker for one tapped ingress port
// Sums accepted bytes per frame and classifies the frame at tlast

`timescale 1ns/1ps

module frame_length_tracker import p4_stats_pkg::*; #(
    parameter type beat_t = beat_8b_t
) (
    input  logic        phys_port_clk_ifc,
    input  logic        rst_n,
    input  beat_t       beat,
    input  logic        enable,
    input  logic        clear,
    output frame_info_t frame
);

    logic                       beat_accepted;
    logic [FRAME_LEN_WIDTH-1:0] beat_bytes;
    logic [FRAME_LEN_WIDTH:0]   len_sum;
    logic [FRAME_LEN_WIDTH-1:0] len_next;
    logic [FRAME_LEN_WIDTH-1:0] run_len;

    logic                       done_q;
    logic [FRAME_LEN_WIDTH-1:0] length_q;
    logic                       runt_q;
    logic                       oversize_q;

    // Disabled ports ignore the beat entirely
    assign beat_accepted = beat.tvalid & beat.tready & enable;

    // Keep bits are contiguous from lane 0, so the popcount is the byte count
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < $bits(beat.tkeep); i++) begin
            beat_bytes = beat_bytes + FRAME_LEN_WIDTH'(beat.tkeep[i]);
        end
    end

    // Saturating running length
    assign len_sum  = {1'b0, run_len} + {1'b0, beat_bytes};
    assign len_next = len_sum[FRAME_LEN_WIDTH] ? '1 : len_sum[FRAME_LEN_WIDTH-1:0];

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= '0;
            done_q  <= 1'b0;
        end else if (clear) begin
            run_len <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= beat_accepted & beat.tlast;
            if (beat_accepted) begin
                run_len <= beat.tlast ? '0 : len_next;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Completed frame record

    always_ff @(posedge phys_port_clk_ifc) begin
        if (beat_accepted && beat.tlast) begin
            length_q   <= len_next;
            runt_q     <= len_next < FRAME_LEN_WIDTH'(PACKET_MIN_BLEN);
            oversize_q <= len_next > FRAME_LEN_WIDTH'(MTU_BYTES);
        end
    end

    assign frame.done     = done_q;
    assign frame.length   = length_q;
    assign frame.runt     = runt_q;
    assign frame.oversize = oversize_q;

endmodule

// ==== rtl/p4_port_stats_top.sv ====
// Ingress statistics top level for the 8-bit and 32-bit physical ports
// Two per-port counter blocks and the aggregator for the totals

`timescale 1ns/1ps

module p4_port_stats_top import p4_stats_pkg::*; (
    input  logic                 phys_port_clk_ifc,
    input  logic                 rst_n,
    input  beat_8b_t             ing_8b_beat,
    input  beat_32b_t            ing_32b_beat,
    input  logic [NUM_PORTS-1:0] ports_enable,
    input  logic [NUM_PORTS-1:0] cnts_clear,
    output port_cnts_t           port_8b_cnts,
    output port_cnts_t           port_32b_cnts,
    output port_cnts_t           total_cnts
);

    //////////////////////////////////////////////////////////////////////
    // Per-port statistics

    phys_port_stats #(
        .beat_t ( beat_8b_t )
    ) u_port_8b (
        .phys_port_clk_ifc ( phys_port_clk_ifc     ),
        .rst_n             ( rst_n                 ),
        .beat              ( ing_8b_beat           ),
        .enable            ( ports_enable[PORT_8B] ),
        .clear             ( cnts_clear[PORT_8B]   ),
        .cnts              ( port_8b_cnts          )
    );

    phys_port_stats #(
        .beat_t ( beat_32b_t )
    ) u_port_32b (
        .phys_port_clk_ifc ( phys_port_clk_ifc      ),
        .rst_n             ( rst_n                  ),
        .beat              ( ing_32b_beat           ),
        .enable            ( ports_enable[PORT_32B] ),
        .clear             ( cnts_clear[PORT_32B]   ),
        .cnts              ( port_32b_cnts          )
    );

    //////////////////////////////////////////////////////////////////////
    // Totals

    stats_aggregator u_stats_aggregator (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .port_8b_cnts      ( port_8b_cnts      ),
        .port_32b_cnts     ( port_32b_cnts     ),
        .total_cnts        ( total_cnts        )
    );

endmodule

// ==== rtl/p4_stats_pkg.sv ====
// Shared types and limits for the ingress port statistics block
// Beat taps, counter records and frame length classification bounds

package p4_stats_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes and limits

    localparam int CNT_WIDTH       = 32;
    localparam int FRAME_LEN_WIDTH = 16;

    // Frame length bounds in bytes
    localparam int PACKET_MIN_BLEN = 64;
    localparam int MTU_BYTES       = 1500;

    localparam int NUM_PORTS = 2;

    // Bit positions in the enable and clear vectors
    localparam int PORT_8B  = 0;
    localparam int PORT_32B = 1;

    //////////////////////////////////////////////////////////////////////
    // Stream beat taps

    // Payload is not carried, only what counting needs
    typedef struct packed {
        logic       tvalid;
        logic       tready;
        logic       tlast;
        logic [0:0] tkeep;
    } beat_8b_t;

    typedef struct packed {
        logic       tvalid;
        logic       tready;
        logic       tlast;
        logic [3:0] tkeep;
    } beat_32b_t;

    //////////////////////////////////////////////////////////////////////
    // Counter and frame records

    typedef struct packed {
        logic [CNT_WIDTH-1:0] frames;
        logic [CNT_WIDTH-1:0] bytes;
        logic [CNT_WIDTH-1:0] runts;
        logic [CNT_WIDTH-1:0] oversize;
    } port_cnts_t;

    // One record per completed frame, done is a single cycle pulse
    typedef struct packed {
        logic                       done;
        logic [FRAME_LEN_WIDTH-1:0] length;
        logic                       runt;
        logic                       oversize;
    } frame_info_t;

endpackage

// ==== rtl/phys_port_stats.sv ====
// Statistics counters for one tapped ingress port
// Counts frames, bytes, runts and oversize frames with enable and clear

`timescale 1ns/1ps

module phys_port_stats import p4_stats_pkg::*; #(
    parameter type beat_t = beat_8b_t
) (
    input  logic       phys_port_clk_ifc,
    input  logic       rst_n,
    input  beat_t      beat,
    input  logic       enable,
    input  logic       clear,
    output port_cnts_t cnts
);

    frame_info_t          frame;
    logic [CNT_WIDTH-1:0] frame_bytes;
    port_cnts_t           cnts_q;
    port_cnts_t           cnts_next;

    //////////////////////////////////////////////////////////////////////
    // Frame length tracking

    frame_length_tracker #(
        .beat_t ( beat_t )
    ) u_frame_length_tracker (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .beat              ( beat              ),
        .enable            ( enable            ),
        .clear             ( clear             ),
        .frame             ( frame             )
    );

    assign frame_bytes = {{(CNT_WIDTH-FRAME_LEN_WIDTH){1'b0}}, frame.length};

    //////////////////////////////////////////////////////////////////////
    // Counter update

    always_comb begin
        cnts_next = cnts_q;
        if (frame.done) begin
            cnts_next.frames   = cnts_q.frames + CNT_WIDTH'(1);
            cnts_next.bytes    = cnts_q.bytes + frame_bytes;
            cnts_next.runts    = cnts_q.runts + CNT_WIDTH'(frame.runt);
            cnts_next.oversize = cnts_q.oversize + CNT_WIDTH'(frame.oversize);
        end
    end

    // Clear wins over a frame completing in the same cycle
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            cnts_q <= '0;
        end else if (clear) begin
            cnts_q <= '0;
        end else begin
            cnts_q <= cnts_next;
        end
    end

    assign cnts = cnts_q;

endmodule

// ==== rtl/stats_aggregator.sv ====
// Router-wide totals over both tapped ingress ports
// Registered field-wise sums of the per-port counters

`timescale 1ns/1ps

module stats_aggregator import p4_stats_pkg::*; (
    input  logic       phys_port_clk_ifc,
    input  logic       rst_n,
    input  port_cnts_t port_8b_cnts,
    input  port_cnts_t port_32b_cnts,
    output port_cnts_t total_cnts
);

    port_cnts_t sum_cnts;
    port_cnts_t total_q;

    //////////////////////////////////////////////////////////////////////
    // Field-wise adders

    always_comb begin
        sum_cnts.frames   = port_8b_cnts.frames + port_32b_cnts.frames;
        sum_cnts.bytes    = port_8b_cnts.bytes + port_32b_cnts.bytes;
        sum_cnts.runts    = port_8b_cnts.runts + port_32b_cnts.runts;
        sum_cnts.oversize = port_8b_cnts.oversize + port_32b_cnts.oversize;
    end

    // One cycle behind the port counters
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            total_q <= '0;
        end else begin
            total_q <= sum_cnts;
        end
    end

    assign total_cnts = total_q;

endmodule

// ==== verification/p4_port_stats_assert.sv ====
// Concurrent checks on the ingress statistics top level
// Reset values, frame count update timing and counter ordering

`timescale 1ns/1ps

module p4_port_stats_assert import p4_stats_pkg::*; (
    input logic                 phys_port_clk_ifc,
    input logic                 rst_n,
    input beat_8b_t             ing_8b_beat,
    input beat_32b_t            ing_32b_beat,
    input logic [NUM_PORTS-1:0] ports_enable,
    input logic [NUM_PORTS-1:0] cnts_clear,
    input port_cnts_t           port_8b_cnts,
    input port_cnts_t           port_32b_cnts,
    input port_cnts_t           total_cnts
);

    logic last_8b;
    logic last_32b;

    // Accepted tlast on an enabled port
    assign last_8b = ing_8b_beat.tvalid & ing_8b_beat.tready & ing_8b_beat.tlast
                     & ports_enable[PORT_8B];
    assign last_32b = ing_32b_beat.tvalid & ing_32b_beat.tready & ing_32b_beat.tlast
                      & ports_enable[PORT_32B];

    a_reset_zero: assert property (@(posedge phys_port_clk_ifc)
        !rst_n |-> (port_8b_cnts == '0 && port_32b_cnts == '0 && total_cnts == '0))
        else $error("counters not zero during reset");

    a_frames_8b: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !$stable(port_8b_cnts.frames) |-> $past(last_8b, 2) || $past(cnts_clear[PORT_8B]))
        else $error("8-bit frame count changed without tlast or clear");

    a_frames_32b: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !$stable(port_32b_cnts.frames) |-> $past(last_32b, 2) || $past(cnts_clear[PORT_32B]))
        else $error("32-bit frame count changed without tlast or clear");

    a_order_8b: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        port_8b_cnts.runts <= port_8b_cnts.frames && port_8b_cnts.oversize <= port_8b_cnts.frames)
        else $error("8-bit runt or oversize count above frame count");

    a_order_32b: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        port_32b_cnts.runts <= port_32b_cnts.frames
        && port_32b_cnts.oversize <= port_32b_cnts.frames)
        else $error("32-bit runt or oversize count above frame count");

endmodule

bind p4_port_stats_top p4_port_stats_assert u_p4_port_stats_assert (
    .phys_port_clk_ifc ( phys_port_clk_ifc ),
    .rst_n             ( rst_n             ),
    .ing_8b_beat       ( ing_8b_beat       ),
    .ing_32b_beat      ( ing_32b_beat      ),
    .ports_enable      ( ports_enable      ),
    .cnts_clear        ( cnts_clear        ),
    .port_8b_cnts      ( port_8b_cnts      ),
    .port_32b_cnts     ( port_32b_cnts     ),
    .total_cnts        ( total_cnts        )
);

// ==== verification/p4_port_stats_tb.sv ====
// Testbench for the ingress port statistics top level
// Drives both tapped ports and checks counters against a reference model

`timescale 1ns/1ps

module p4_port_stats_tb import p4_stats_pkg::*; ();

    localparam int          RESET_CYCLES      = 3;
    localparam int          IDLE_CYCLES       = 5;
    localparam int          FRAME_CYCLE_LIMIT = 8000;
    localparam int          ACK_CYCLE_LIMIT   = 40;
    localparam int          REQ_CYCLE_LIMIT   = 200000;
    localparam logic [31:0] SEED              = 32'd77588;

    logic                 phys_port_clk_ifc = 1'b0;
    logic                 rst_n;
    beat_8b_t             ing_8b_beat;
    beat_32b_t            ing_32b_beat;
    logic [NUM_PORTS-1:0] ports_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    port_cnts_t           port_8b_cnts;
    port_cnts_t           port_32b_cnts;
    port_cnts_t           total_cnts;

    logic [31:0] rng_state;
    int unsigned lens_8b[$];
    int unsigned lens_32b[$];
    int unsigned sent_8b[$];
    int unsigned sent_32b[$];
    int          check_req = 0;
    int          check_ack = 0;

    always #2 phys_port_clk_ifc = ~phys_port_clk_ifc;

    p4_port_stats_top u_p4_port_stats_top (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .ing_8b_beat       ( ing_8b_beat       ),
        .ing_32b_beat      ( ing_32b_beat      ),
        .ports_enable      ( ports_enable      ),
        .cnts_clear        ( cnts_clear        ),
        .port_8b_cnts      ( port_8b_cnts      ),
        .port_32b_cnts     ( port_32b_cnts     ),
        .total_cnts        ( total_cnts        )
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected counters for a list of completed frame lengths
    function automatic port_cnts_t expected_cnts(input int unsigned lens[$]);
        port_cnts_t exp;
        exp = '0;
        foreach (lens[i]) begin
            exp.frames = exp.frames + 1;
            exp.bytes  = exp.bytes + lens[i];
            if (lens[i] < PACKET_MIN_BLEN) exp.runts = exp.runts + 1;
            if (lens[i] > MTU_BYTES) exp.oversize = exp.oversize + 1;
        end
        return exp;
    endfunction

    function automatic port_cnts_t sum_cnts(input port_cnts_t a, input port_cnts_t b);
        port_cnts_t s;
        s.frames   = a.frames + b.frames;
        s.bytes    = a.bytes + b.bytes;
        s.runts    = a.runts + b.runts;
        s.oversize = a.oversize + b.oversize;
        return s;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Fields in frames/bytes/runts/oversize order
    task automatic check_cnts(input string what, input port_cnts_t got, input port_cnts_t exp);
        assert (got == exp) else begin
            fail_run($sformatf(
                "ERROR at %0d ns: %s got %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
                $time, what, got.frames, got.bytes, got.runts, got.oversize,
                exp.frames, exp.bytes, exp.runts, exp.oversize));
        end
    endtask

    task automatic make_random_lens(input int count, input int unsigned lo, input int unsigned hi);
        lens_8b.delete();
        lens_32b.delete();
        repeat (count) begin
            rng_state = lcg_next(rng_state);
            lens_8b.push_back(lo + {8'd0, rng_state[31:8]} % (hi - lo + 1));
            rng_state = lcg_next(rng_state);
            lens_32b.push_back(lo + {8'd0, rng_state[31:8]} % (hi - lo + 1));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    // One frame, one beat per cycle, tready optionally dropped at random
    task automatic send_frame(input int port, input int unsigned len, input bit stalls,
                              inout logic [31:0] st);
        int unsigned left;
        int unsigned lane;
        int unsigned n;
        int          cycles;
        logic        ready;
        left   = len;
        lane   = (port == PORT_32B) ? 4 : 1;
        cycles = 0;
        while (left > 0) begin
            n     = (left > lane) ? lane : left;
            st    = lcg_next(st);
            ready = !(stalls && st[31:30] == 2'b00);
            if (port == PORT_32B) begin
                ing_32b_beat.tvalid = 1'b1;
                ing_32b_beat.tready = ready;
                ing_32b_beat.tlast  = (n == left);
                ing_32b_beat.tkeep  = 4'((1 << n) - 1);
            end else begin
                ing_8b_beat.tvalid = 1'b1;
                ing_8b_beat.tready = ready;
                ing_8b_beat.tlast  = (n == left);
                ing_8b_beat.tkeep  = 1'b1;
            end
            @(posedge phys_port_clk_ifc);
            #1;
            if (ready) left = left - n;
            cycles++;
            if (cycles > FRAME_CYCLE_LIMIT) begin
                fail_run($sformatf("Frame of %0d bytes on port %0d never completed", len, port));
            end
        end
        if (port == PORT_32B) ing_32b_beat = '0;
        else ing_8b_beat = '0;
    endtask

    task automatic send_frames(input int port, input int unsigned lens[$], input bit stalls,
                               input logic [31:0] seed);
        logic [31:0] st;
        st = seed;
        foreach (lens[i]) begin
            send_frame(port, lens[i], stalls, st);
            @(posedge phys_port_clk_ifc);
            #1;
        end
    endtask

    task automatic request_check();
        int waited;
        waited = 0;
        check_req++;
        while (check_ack != check_req) begin
            @(posedge phys_port_clk_ifc);
            waited++;
            if (waited > ACK_CYCLE_LIMIT) fail_run("Counter check never completed");
        end
        #1;
    endtask

    // Both ports in parallel, then a full counter check
    task automatic run_phase(input bit stalls);
        logic [31:0] seed_8b;
        logic [31:0] seed_32b;
        rng_state = lcg_next(rng_state);
        seed_8b   = rng_state;
        rng_state = lcg_next(rng_state);
        seed_32b  = rng_state;
        fork
            send_frames(PORT_8B, lens_8b, stalls, seed_8b);
            send_frames(PORT_32B, lens_32b, stalls, seed_32b);
        join
        if (ports_enable[PORT_8B]) begin
            foreach (lens_8b[i]) sent_8b.push_back(lens_8b[i]);
        end
        if (ports_enable[PORT_32B]) begin
            foreach (lens_32b[i]) sent_32b.push_back(lens_32b[i]);
        end
        request_check();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checker that runs once per request after the pipeline has drained

    initial begin : compare_proc
        int         waited;
        port_cnts_t exp_8b;
        port_cnts_t exp_32b;
        forever begin
            waited = 0;
            while (check_req == check_ack) begin
                @(negedge phys_port_clk_ifc);
                waited++;
                if (waited > REQ_CYCLE_LIMIT) fail_run("No check requested, stimulus stuck");
            end
            repeat (IDLE_CYCLES) @(posedge phys_port_clk_ifc);
            @(negedge phys_port_clk_ifc);
            exp_8b  = expected_cnts(sent_8b);
            exp_32b = expected_cnts(sent_32b);
            check_cnts("8-bit port", port_8b_cnts, exp_8b);
            check_cnts("32-bit port", port_32b_cnts, exp_32b);
            check_cnts("total", total_cnts, sum_cnts(exp_8b, exp_32b));
            check_ack++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int unsigned edge_lens [6];
        edge_lens    = '{20, 63, 64, 1500, 1501, 1600};
        rng_state    = SEED;
        ing_8b_beat  = '0;
        ing_32b_beat = '0;
        ports_enable = '1;
        cnts_clear   = '0;
        rst_n        = 1'b1;
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge phys_port_clk_ifc);
        #1;
        rst_n = 1'b1;
        @(posedge phys_port_clk_ifc);
        #1;

        request_check();

        // Legal lengths, no stalls
        make_random_lens(10, PACKET_MIN_BLEN, MTU_BYTES);
        run_phase(1'b0);

        // Runt and oversize boundaries
        lens_8b.delete();
        foreach (edge_lens[i]) lens_8b.push_back(edge_lens[i]);
        lens_32b = lens_8b;
        run_phase(1'b0);

        make_random_lens(6, 1, 1600);
        run_phase(1'b1);

        // 32-bit port disabled
        ports_enable[PORT_32B] = 1'b0;
        make_random_lens(4, PACKET_MIN_BLEN, MTU_BYTES);
        run_phase(1'b0);
        ports_enable[PORT_32B] = 1'b1;

        // Clear the 8-bit port only
        cnts_clear[PORT_8B] = 1'b1;
        @(posedge phys_port_clk_ifc);
        #1;
        cnts_clear[PORT_8B] = 1'b0;
        @(posedge phys_port_clk_ifc);
        @(negedge phys_port_clk_ifc);
        sent_8b.delete();
        check_cnts("8-bit port after clear", port_8b_cnts, expected_cnts(sent_8b));
        check_cnts("total after clear", total_cnts, expected_cnts(sent_32b));
        @(posedge phys_port_clk_ifc);
        #1;

        make_random_lens(3, 1, 1600);
        run_phase(1'b1);

        $display("Result: PASSED");
        $finish;
    end

endmodule
